//--- trap_unit.f
logic/trap_pkg.sv
logic/trap_fsm.sv
logic/trap_capture.sv
logic/machine_timer.sv
logic/mcsr_file.sv
logic/trap_unit_top.sv
bench/trap_assertions.sv
bench/tb_trap_unit.sv

//--- Makefile
# Verilator build for the trap unit testbench

VERILATOR ?= verilator
TOP       := tb_trap_unit
FILELIST  := trap_unit.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_trap_unit.sv
// trap unit testbench: clock, reset, lfsr, check task, event table, mret, atomic stall, timer
`default_nettype none

module tb_trap_unit;
    import trap_pkg::*;

    localparam int        N_ENT   = 10;
    localparam csr_addr_t A_MTIME = 12'hC01;
    // strobe mask {store, load, fetch, illegal, ebreak, ecall}
    localparam logic [5:0] K_ECALL = 6'b000001, K_EBREAK = 6'b000010, K_ILLEGAL = 6'b000100;
    localparam logic [5:0] K_FETCH = 6'b001000, K_LOAD = 6'b010000, K_STORE = 6'b100000;
    localparam csr_addr_t ZERO_CSRS [6] = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC,
                                            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL};

    typedef struct packed {
        logic [5:0]  kind;
        logic        jump;
        logic        atom;      // hold atom_busy first
        logic [31:0] inst_addr, jump_addr, illegal_pc, illegal_val, ex_pc, ex_val;
        logic [31:0] exp_cause, exp_mepc, exp_mtval;
        logic        exp_tval;
    } entry_t;

    logic        clk, rst_n;
    logic        ecall, ebreak, illegal, fetch_mis, load_mis, store_mis, mret, atom_busy;
    logic        jump, host_we, flush, stall, redirect;
    xlen_t       inst_addr, jump_addr, illegal_pc, illegal_val, ex_pc, ex_val;
    xlen_t       host_wdata, host_rdata, redirect_pc;
    csr_addr_t   host_addr, host_raddr;
    entry_t      ent_tab [N_ENT];
    logic [31:0] lfsr_q = 32'hdd90_ee4a;
    logic [31:0] mtvec_val;
    logic [31:0] ms_model;    // expected mstatus

    trap_unit_top #(.TICK_DIV(4)) i_dut (
        .clk(clk), .rst_n(rst_n), .ecall_i(ecall), .ebreak_i(ebreak), .illegal_i(illegal),
        .fetch_misalign_i(fetch_mis), .load_misalign_i(load_mis),
        .store_misalign_i(store_mis), .mret_i(mret), .atom_busy_i(atom_busy),
        .inst_addr_i(inst_addr), .jump_i(jump), .jump_addr_i(jump_addr),
        .illegal_pc_i(illegal_pc), .illegal_val_i(illegal_val), .ex_pc_i(ex_pc),
        .ex_val_i(ex_val), .host_we_i(host_we), .host_addr_i(host_addr),
        .host_wdata_i(host_wdata), .host_raddr_i(host_raddr), .host_rdata_o(host_rdata),
        .flush_o(flush), .stall_o(stall), .redirect_o(redirect), .redirect_pc_o(redirect_pc)
    );

    bind trap_fsm trap_assertions i_assert (
        .clk(clk), .rst_n(rst_n), .state_i(state_q), .flush_i(flush_o),
        .redirect_i(redirect_o), .seq_we_i(seq_we_o)
    );

    always #10 clk = ~clk;

    // --------------------
    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic step();
        @(posedge clk);
        #2;  // drive and sample away from the edge
    endtask

    task automatic host_write(input csr_addr_t addr, input logic [31:0] data);
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        step();
        host_we    = 1'b0;
    endtask

    task automatic expect_csr(input string name, input csr_addr_t addr, input logic [31:0] exp);
        host_raddr = addr;
        #1;
        check(name, host_rdata, exp);
        step();  // one read per cycle
    endtask

    task automatic wait_redirect(input int limit, output int cycles);
        cycles = 0;
        do begin
            step();
            cycles++;
        end while (!redirect && cycles < limit);
        if (!redirect) stop_run("timeout waiting for redirect_o");
    endtask

    // --------------------
    // event table, expected values by cause and mepc priority
    task automatic build_table();
        logic [5:0]  kinds [N_ENT];
        logic [5:0]  k;
        logic [31:0] tval_model;
        entry_t      e;
        kinds = '{K_ECALL, K_ECALL, K_EBREAK, K_ILLEGAL, K_FETCH, K_LOAD, K_STORE,
                  K_ECALL | K_ILLEGAL | K_LOAD, K_FETCH | K_STORE, K_EBREAK | K_ILLEGAL};
        tval_model = '0;
        for (int i = 0; i < N_ENT; i++) begin
            k             = kinds[i];
            e.kind        = k;
            e.jump        = (i == 1);   // ecall behind a jump
            e.atom        = (i == 2);   // ebreak behind an atomic op
            e.inst_addr   = rand_word() & ~32'h3;
            e.jump_addr   = rand_word() & ~32'h3;
            e.illegal_pc  = rand_word() & ~32'h3;
            e.illegal_val = rand_word();
            e.ex_pc       = rand_word();
            e.ex_val      = rand_word();
            if (k[0])      e.exp_cause = 32'd11;
            else if (k[1]) e.exp_cause = 32'd3;
            else if (k[3]) e.exp_cause = 32'd0;
            else if (k[4]) e.exp_cause = 32'd4;
            else if (k[5]) e.exp_cause = 32'd6;
            else           e.exp_cause = 32'd2;
            if (|k[5:3])     e.exp_mepc = e.ex_pc;
            else if (k[2])   e.exp_mepc = e.illegal_pc;
            else if (e.jump) e.exp_mepc = e.jump_addr - 32'd4;
            else             e.exp_mepc = e.inst_addr;
            e.exp_tval = k[4] | k[5] | k[2];
            if (k[4] | k[5]) tval_model = e.ex_val;
            else if (k[2])   tval_model = e.illegal_val;
            e.exp_mtval = tval_model;  // mtval kept when not written
            ent_tab[i]  = e;
        end
    endtask

    task automatic run_entry(input entry_t e);
        int cyc;
        inst_addr   = e.inst_addr;
        jump_addr   = e.jump_addr;
        illegal_pc  = e.illegal_pc;
        illegal_val = e.illegal_val;
        ex_pc       = e.ex_pc;
        ex_val      = e.ex_val;
        jump        = e.jump;
        {store_mis, load_mis, fetch_mis, illegal, ebreak, ecall} = e.kind;
        if (e.atom) begin
            atom_busy = 1'b1;
            repeat (3) begin
                #1;
                check("stall_o", 32'(stall), 32'd1);
                check("flush_o", 32'(flush), 32'd0);  // nothing started
                step();
            end
            atom_busy = 1'b0;
        end
        step();  // accepting edge
        {store_mis, load_mis, fetch_mis, illegal, ebreak, ecall} = '0;
        jump = 1'b0;
        wait_redirect(20, cyc);
        check("trap latency", 32'(cyc), e.exp_tval ? 32'd5 : 32'd4);
        check("redirect_pc_o", redirect_pc, mtvec_val);
        ms_model[7] = ms_model[3];
        ms_model[3] = 1'b0;
        expect_csr("mcause", CSR_MCAUSE, e.exp_cause);
        expect_csr("mepc", CSR_MEPC, e.exp_mepc);
        expect_csr("mtval", CSR_MTVAL, e.exp_mtval);
        expect_csr("mstatus", CSR_MSTATUS, ms_model);
        // return from the trap
        mret = 1'b1;
        step();
        mret = 1'b0;
        wait_redirect(20, cyc);
        check("mret latency", 32'(cyc), 32'd2);
        check("redirect_pc_o", redirect_pc, e.exp_mepc);
        ms_model[3] = ms_model[7];
        ms_model[7] = 1'b1;
        expect_csr("mstatus", CSR_MSTATUS, ms_model);
    endtask

    // --------------------
    initial begin
        int          cyc;
        logic [31:0] t;
        clk = 1'b0;
        rst_n = 1'b0;
        {store_mis, load_mis, fetch_mis, illegal, ebreak, ecall} = '0;
        {mret, atom_busy, jump, host_we} = '0;
        {inst_addr, jump_addr, illegal_pc, illegal_val, ex_pc, ex_val} = '0;
        host_wdata = '0;
        host_addr  = '0;
        host_raddr = '0;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check("flush_o", 32'(flush), 32'd0);
        check("stall_o", 32'(stall), 32'd0);
        check("redirect_o", 32'(redirect), 32'd0);
        foreach (ZERO_CSRS[i]) expect_csr($sformatf("csr %h", ZERO_CSRS[i]), ZERO_CSRS[i], '0);
        mtvec_val = rand_word() & ~32'h3;
        host_write(CSR_MTVEC, mtvec_val);
        ms_model = 32'h8;  // global enable on
        host_write(CSR_MSTATUS, ms_model);
        for (int i = 0; i < N_ENT; i++) begin
            run_entry(ent_tab[i]);
        end
        // timer interrupt, armed a few ticks ahead
        inst_addr = rand_word() & ~32'h3;
        host_write(CSR_MIE, 32'h80);
        host_raddr = A_MTIME;
        #1;
        t = host_rdata;
        step();
        host_write(CSR_MTIMECMP, t + 32'd3);
        wait_redirect(40, cyc);
        check("redirect_pc_o", redirect_pc, mtvec_val);
        ms_model[7] = ms_model[3];
        ms_model[3] = 1'b0;
        expect_csr("mcause", CSR_MCAUSE, 32'h8000_0007);
        expect_csr("mepc", CSR_MEPC, inst_addr);
        expect_csr("mstatus", CSR_MSTATUS, ms_model);
        // still pending, but mie now masked
        repeat (40) begin
            step();
            if (redirect) stop_run("redirect_o taken while mstatus MIE is clear");
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/trap_assertions.sv
// sequencer checks: flush while busy, one-cycle redirect, no csr write in idle, redirect back in idle
`default_nettype none

module trap_assertions (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire trap_pkg::trap_state_e  state_i,
    input wire logic                   flush_i,
    input wire logic                   redirect_i,
    input wire logic                   seq_we_i
);
    import trap_pkg::*;

    // --------------------
    a_flush_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i != IDLE) |-> flush_i)
        else $error("flush_o low while the sequencer is busy");

    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |=> !redirect_i)  // single cycle pulse
        else $error("redirect_o held for more than one cycle");

    a_no_we_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == IDLE) |-> !seq_we_i)
        else $error("csr write strobe raised in idle");

    // redirect register trails the redirect state by one edge
    a_redirect_idle: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |-> (state_i == IDLE))
        else $error("sequencer not back in idle at redirect");

endmodule

`default_nettype wire

//--- logic/trap_unit_top.sv
// trap unit top: sequencer, capture, machine timer and machine csr file
`default_nettype none

module trap_unit_top #(
    parameter int unsigned TICK_DIV = 4  // mtime prescale
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    // exception strobes, decode and execute
    input  wire logic                 ecall_i,
    input  wire logic                 ebreak_i,
    input  wire logic                 illegal_i,
    input  wire logic                 fetch_misalign_i,
    input  wire logic                 load_misalign_i,
    input  wire logic                 store_misalign_i,
    input  wire logic                 mret_i,
    input  wire logic                 atom_busy_i,
    // pcs and faulting values
    input  wire trap_pkg::xlen_t      inst_addr_i,
    input  wire logic                 jump_i,
    input  wire trap_pkg::xlen_t      jump_addr_i,
    input  wire trap_pkg::xlen_t      illegal_pc_i,
    input  wire trap_pkg::xlen_t      illegal_val_i,
    input  wire trap_pkg::xlen_t      ex_pc_i,
    input  wire trap_pkg::xlen_t      ex_val_i,
    // host csr port
    input  wire logic                 host_we_i,
    input  wire trap_pkg::csr_addr_t  host_addr_i,
    input  wire trap_pkg::xlen_t      host_wdata_i,
    input  wire trap_pkg::csr_addr_t  host_raddr_i,
    output trap_pkg::xlen_t           host_rdata_o,
    // pipeline control
    output logic                      flush_o,
    output logic                      stall_o,
    output logic                      redirect_o,
    output trap_pkg::xlen_t           redirect_pc_o
);
    import trap_pkg::*;

    logic      exc_req;
    logic      capture;
    logic      has_tval;
    logic      seq_we;
    csr_addr_t seq_addr;
    logic      seq_mret;
    cause_t    cause;
    xlen_t     epc;
    xlen_t     tval;
    xlen_t     mtvec;
    xlen_t     mepc;
    xlen_t     mtime;
    logic      cmp_we;
    xlen_t     cmp_wdata;
    logic      timer_pending;
    logic      mstatus_mie;
    logic      mie_mtie;

    // timer interrupt gated by global and local enable
    wire logic timer_take = timer_pending & mstatus_mie & mie_mtie;

    trap_fsm i_fsm (
        .clk, .rst_n, .exc_req_i(exc_req), .mret_i, .atom_busy_i,
        .timer_take_i(timer_take), .has_tval_i(has_tval),
        .mtvec_i(mtvec), .mepc_i(mepc), .capture_o(capture),
        .seq_we_o(seq_we), .seq_addr_o(seq_addr), .seq_mret_o(seq_mret),
        .flush_o, .stall_o, .redirect_o, .redirect_pc_o
    );

    trap_capture i_capture (
        .clk, .rst_n, .capture_i(capture), .ecall_i, .ebreak_i, .illegal_i,
        .fetch_misalign_i, .load_misalign_i, .store_misalign_i,
        .timer_take_i(timer_take), .jump_i, .jump_addr_i, .inst_addr_i,
        .illegal_pc_i, .illegal_val_i, .ex_pc_i, .ex_val_i,
        .exc_req_o(exc_req), .cause_o(cause), .epc_o(epc), .tval_o(tval),
        .has_tval_o(has_tval)
    );

    machine_timer #(.TICK_DIV(TICK_DIV)) i_timer (
        .clk, .rst_n, .cmp_we_i(cmp_we), .cmp_wdata_i(cmp_wdata),
        .mtime_o(mtime), .timer_pending_o(timer_pending)
    );

    mcsr_file i_csr (
        .clk, .rst_n, .seq_we_i(seq_we), .seq_addr_i(seq_addr), .seq_mret_i(seq_mret),
        .epc_i(epc), .cause_i(cause), .tval_i(tval),
        .host_we_i, .host_addr_i, .host_wdata_i, .host_raddr_i, .mtime_i(mtime),
        .host_rdata_o, .mstatus_mie_o(mstatus_mie), .mie_mtie_o(mie_mtie),
        .mtvec_o(mtvec), .mepc_o(mepc), .cmp_we_o(cmp_we), .cmp_wdata_o(cmp_wdata)
    );

endmodule

`default_nettype wire

//--- logic/mcsr_file.sv
// machine csr file: csr registers, sequencer/host write arbitration, mstatus updates, read mux
`default_nettype none

module mcsr_file (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 seq_we_i,      // sequencer write, wins over host
    input  wire trap_pkg::csr_addr_t  seq_addr_i,
    input  wire logic                 seq_mret_i,    // mstatus write is an mret restore
    input  wire trap_pkg::xlen_t      epc_i,
    input  wire trap_pkg::cause_t     cause_i,
    input  wire trap_pkg::xlen_t      tval_i,
    input  wire logic                 host_we_i,
    input  wire trap_pkg::csr_addr_t  host_addr_i,
    input  wire trap_pkg::xlen_t      host_wdata_i,
    input  wire trap_pkg::csr_addr_t  host_raddr_i,
    input  wire trap_pkg::xlen_t      mtime_i,
    output trap_pkg::xlen_t           host_rdata_o,
    output logic                      mstatus_mie_o,
    output logic                      mie_mtie_o,
    output trap_pkg::xlen_t           mtvec_o,
    output trap_pkg::xlen_t           mepc_o,
    output logic                      cmp_we_o,      // to timer
    output trap_pkg::xlen_t           cmp_wdata_o
);
    import trap_pkg::*;

    localparam csr_addr_t CSR_MTIME = 12'hC01;  // read-only time view

    xlen_t     mstatus_q;
    xlen_t     mie_q;
    xlen_t     mtvec_q;
    xlen_t     mepc_q;
    cause_t    mcause_q;
    xlen_t     mtval_q;
    xlen_t     mstatus_upd;  // entry or return value
    xlen_t     seq_wdata;
    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;

    // --------------------
    // sequencer data per address
    always_comb begin
        mstatus_upd = mstatus_q;
        if (seq_mret_i) begin
            mstatus_upd[MSTATUS_MIE]  = mstatus_q[MSTATUS_MPIE];
            mstatus_upd[MSTATUS_MPIE] = 1'b1;
        end else begin
            mstatus_upd[MSTATUS_MPIE] = mstatus_q[MSTATUS_MIE];  // save, then mask
            mstatus_upd[MSTATUS_MIE]  = 1'b0;
        end
        case (seq_addr_i)
            CSR_MEPC:   seq_wdata = epc_i;
            CSR_MCAUSE: seq_wdata = cause_i;
            CSR_MTVAL:  seq_wdata = tval_i;
            default:    seq_wdata = mstatus_upd;
        endcase
    end

    // host write dropped in a sequencer write cycle
    assign wr_en   = seq_we_i | host_we_i;
    assign wr_addr = seq_we_i ? seq_addr_i : host_addr_i;
    assign wr_data = seq_we_i ? seq_wdata  : host_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
            mtval_q   <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                CSR_MSTATUS: mstatus_q <= wr_data;
                CSR_MIE:     mie_q     <= wr_data;
                CSR_MTVEC:   mtvec_q   <= wr_data;  // direct mode only
                CSR_MEPC:    mepc_q    <= wr_data;
                CSR_MCAUSE:  mcause_q  <= wr_data;
                CSR_MTVAL:   mtval_q   <= wr_data;
                default:     ;                      // mtimecmp goes to timer
            endcase
        end
    end

    assign cmp_we_o    = host_we_i & ~seq_we_i & (host_addr_i == CSR_MTIMECMP);
    assign cmp_wdata_o = host_wdata_i;

    // --------------------
    // read mux, mtimecmp write-only here
    always_comb begin
        case (host_raddr_i)
            CSR_MSTATUS: host_rdata_o = mstatus_q;
            CSR_MIE:     host_rdata_o = mie_q;
            CSR_MTVEC:   host_rdata_o = mtvec_q;
            CSR_MEPC:    host_rdata_o = mepc_q;
            CSR_MCAUSE:  host_rdata_o = mcause_q;
            CSR_MTVAL:   host_rdata_o = mtval_q;
            CSR_MTIME:   host_rdata_o = mtime_i;
            default:     host_rdata_o = '0;
        endcase
    end

    assign mstatus_mie_o = mstatus_q[MSTATUS_MIE];
    assign mie_mtie_o    = mie_q[MIE_MTIE];
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

endmodule

`default_nettype wire

//--- logic/machine_timer.sv
// machine timer: prescaled 32-bit mtime, mtimecmp register and timer-pending compare
`default_nettype none

module machine_timer #(
    parameter int unsigned TICK_DIV = 4  // clocks per mtime tick, 1 or more
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             cmp_we_i,     // host write to mtimecmp
    input  wire trap_pkg::xlen_t  cmp_wdata_i,
    output trap_pkg::xlen_t       mtime_o,
    output logic                  timer_pending_o
);
    import trap_pkg::*;

    localparam int unsigned PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [PW-1:0] PRE_MAX = PW'(TICK_DIV - 1);

    logic [PW-1:0] pre_q;       // prescale count
    xlen_t         mtime_q;
    xlen_t         mtimecmp_q;

    // --------------------
    // prescaler and mtime
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_q   <= '0;
            mtime_q <= '0;
        end else if (pre_q == PRE_MAX) begin
            pre_q   <= '0;
            mtime_q <= mtime_q + 32'd1;  // wraps at 2^32
        end else begin
            pre_q   <= pre_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)        mtimecmp_q <= '0;
        else if (cmp_we_i) mtimecmp_q <= cmp_wdata_i;
    end

    // zero compare value means timer disarmed
    assign timer_pending_o = (mtime_q >= mtimecmp_q) && (mtimecmp_q != '0);
    assign mtime_o         = mtime_q;

endmodule

`default_nettype wire

//--- logic/trap_capture.sv
// trap capture: exception request, cause, mepc and mtval priority select and latches
`default_nettype none

module trap_capture (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             capture_i,        // accept cycle from sequencer
    input  wire logic             ecall_i,
    input  wire logic             ebreak_i,
    input  wire logic             illegal_i,
    input  wire logic             fetch_misalign_i,
    input  wire logic             load_misalign_i,
    input  wire logic             store_misalign_i,
    input  wire logic             timer_take_i,
    input  wire logic             jump_i,           // ex stage is taking a jump
    input  wire trap_pkg::xlen_t  jump_addr_i,
    input  wire trap_pkg::xlen_t  inst_addr_i,      // id stage pc
    input  wire trap_pkg::xlen_t  illegal_pc_i,
    input  wire trap_pkg::xlen_t  illegal_val_i,
    input  wire trap_pkg::xlen_t  ex_pc_i,
    input  wire trap_pkg::xlen_t  ex_val_i,
    output logic                  exc_req_o,
    output trap_pkg::cause_t      cause_o,
    output trap_pkg::xlen_t       epc_o,
    output trap_pkg::xlen_t       tval_o,
    output logic                  has_tval_o
);
    import trap_pkg::*;

    cause_t cause_q;
    xlen_t  epc_q;
    xlen_t  tval_q;
    logic   has_tval_q;

    assign exc_req_o = ecall_i | ebreak_i | illegal_i
                     | fetch_misalign_i | load_misalign_i | store_misalign_i;

    // --------------------
    // payload latches
    always_ff @(posedge clk) begin
        if (capture_i) begin
            // cause priority
            if (ecall_i)               cause_q <= CAUSE_ECALL;
            else if (ebreak_i)         cause_q <= CAUSE_EBREAK;
            else if (fetch_misalign_i) cause_q <= CAUSE_FETCH_MISALIGN;
            else if (load_misalign_i)  cause_q <= CAUSE_LOAD_MISALIGN;
            else if (store_misalign_i) cause_q <= CAUSE_STORE_MISALIGN;
            else if (illegal_i)        cause_q <= CAUSE_ILLEGAL;
            else if (timer_take_i)     cause_q <= CAUSE_TIMER_INT;
            // return address
            if (fetch_misalign_i || load_misalign_i || store_misalign_i) epc_q <= ex_pc_i;
            else if (illegal_i) epc_q <= illegal_pc_i;
            else if (jump_i)    epc_q <= jump_addr_i - 32'd4;  // jump target already in flight
            else                epc_q <= inst_addr_i;
            // faulting value
            if (load_misalign_i || store_misalign_i) tval_q <= ex_val_i;
            else if (illegal_i) tval_q <= illegal_val_i;
            else                tval_q <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)         has_tval_q <= 1'b0;
        else if (capture_i) has_tval_q <= load_misalign_i | store_misalign_i | illegal_i;
    end

    assign cause_o    = cause_q;
    assign epc_o      = epc_q;
    assign tval_o     = tval_q;
    assign has_tval_o = has_tval_q;

endmodule

`default_nettype wire

//--- logic/trap_fsm.sv
// trap sequencer: event acceptance and priority, csr write strobes, flush, stall, redirect
`default_nettype none

module trap_fsm (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             exc_req_i,     // or of sync exception strobes
    input  wire logic             mret_i,
    input  wire logic             atom_busy_i,   // atomic op blocks exceptions
    input  wire logic             timer_take_i,  // timer pending and enabled
    input  wire logic             has_tval_i,    // from capture, valid after accept
    input  wire trap_pkg::xlen_t  mtvec_i,
    input  wire trap_pkg::xlen_t  mepc_i,
    output logic                  capture_o,     // latch cause/epc/tval now
    output logic                  seq_we_o,
    output trap_pkg::csr_addr_t   seq_addr_o,
    output logic                  seq_mret_o,    // mstatus write is the return update
    output logic                  flush_o,
    output logic                  stall_o,
    output logic                  redirect_o,
    output trap_pkg::xlen_t       redirect_pc_o
);
    import trap_pkg::*;

    trap_state_e state_q;
    trap_state_e state_d;
    logic        mret_q;         // running sequence is an mret
    logic        redirect_q;
    xlen_t       redirect_pc_q;
    logic        exc_take;
    logic        mret_take;
    logic        timer_take;
    logic        idle;

    // --------------------
    // acceptance, exceptions over mret over timer
    assign idle       = (state_q == IDLE);
    assign exc_take   = exc_req_i & ~atom_busy_i;
    assign mret_take  = mret_i & ~exc_req_i;
    assign timer_take = timer_take_i & ~exc_req_i & ~mret_i;

    assign capture_o = idle & (exc_take | timer_take);  // mret has nothing to latch
    assign stall_o   = exc_req_i & atom_busy_i;         // hold pipe until atomic done
    assign flush_o   = ~idle;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (exc_take || timer_take) state_d = WR_MEPC;
                else if (mret_take)         state_d = WR_MSTATUS_MRET;
            end
            WR_MEPC:         state_d = WR_MSTATUS;
            WR_MSTATUS:      state_d = has_tval_i ? WR_MTVAL : WR_MCAUSE;
            WR_MTVAL:        state_d = WR_MCAUSE;
            WR_MCAUSE:       state_d = REDIRECT;
            WR_MSTATUS_MRET: state_d = REDIRECT;
            REDIRECT:        state_d = IDLE;
            default:         state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            mret_q     <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            redirect_q <= (state_q == REDIRECT);  // one cycle after the redirect state
            if (idle) mret_q <= mret_take;
        end
    end

    // target sampled in redirect state, csr writes are done by then
    always_ff @(posedge clk) begin
        if (state_q == REDIRECT) redirect_pc_q <= mret_q ? mepc_i : mtvec_i;
    end

    // --------------------
    // csr write strobes, write lands at the edge leaving the state
    always_comb begin
        seq_we_o   = 1'b1;
        seq_addr_o = CSR_MSTATUS;
        case (state_q)
            WR_MEPC:                     seq_addr_o = CSR_MEPC;
            WR_MSTATUS, WR_MSTATUS_MRET: seq_addr_o = CSR_MSTATUS;
            WR_MTVAL:                    seq_addr_o = CSR_MTVAL;
            WR_MCAUSE:                   seq_addr_o = CSR_MCAUSE;
            default:                     seq_we_o   = 1'b0;  // idle, redirect
        endcase
    end

    assign seq_mret_o    = mret_q;
    assign redirect_o    = redirect_q;
    assign redirect_pc_o = redirect_pc_q;

endmodule

`default_nettype wire

//--- logic/trap_pkg.sv
// trap unit package: word and csr address types, csr addresses, cause codes, status bits, fsm states
`default_nettype none

package trap_pkg;

    // --------------------
    // widths
    typedef logic [31:0] xlen_t;      // machine word
    typedef logic [11:0] csr_addr_t;  // csr address space
    typedef logic [31:0] cause_t;     // mcause value, bit 31 = interrupt

    // --------------------
    // machine csr addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MTIMECMP = 12'h7C0;  // custom, machine rw range

    // --------------------
    // mcause codes
    localparam cause_t CAUSE_FETCH_MISALIGN = 32'd0;
    localparam cause_t CAUSE_ILLEGAL        = 32'd2;
    localparam cause_t CAUSE_EBREAK         = 32'd3;
    localparam cause_t CAUSE_LOAD_MISALIGN  = 32'd4;
    localparam cause_t CAUSE_STORE_MISALIGN = 32'd6;
    localparam cause_t CAUSE_ECALL          = 32'd11;  // ecall from m-mode
    localparam cause_t CAUSE_TIMER_INT      = 32'h8000_0007;

    // status and enable bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MIE_MTIE     = 7;

    // trap sequencer states
    typedef enum logic [2:0] {
        IDLE, WR_MEPC, WR_MSTATUS, WR_MTVAL, WR_MCAUSE, WR_MSTATUS_MRET, REDIRECT
    } trap_state_e;

endpackage

`default_nettype wire
